//--- design/pwo_pkg.sv
// Pointwise engine shared definitions
`default_nettype none

package pwo_pkg;

    // ============================================================
    // Field and storage constants
    // ============================================================
    localparam int unsigned MLDSA_Q = 8380417;
    localparam int COEFF_W = 23;
    localparam int SLOT_W = 24;
    localparam int COEFFS_PER_WORD = 4;
    localparam int WORD_W = COEFFS_PER_WORD * SLOT_W;
    localparam int MEM_ADDR_W = 15;

    // Cycles from read request to write request
    localparam int PIPE_LAT = 5;

    // ============================================================
    // Word layout
    // ============================================================
    typedef logic [COEFF_W-1:0] coeff_t;

    typedef struct packed {
        logic [SLOT_W-COEFF_W-1:0] pad;
        coeff_t                    coeff;
    } slot_t;

    // Slot 0 in the low bits
    typedef slot_t [COEFFS_PER_WORD-1:0] mem_word_t;

    // ============================================================
    // Modes and memory requests
    // ============================================================
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_e;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_cmd_e;

    typedef struct packed {
        rw_cmd_e                rd_wr_en;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic [MEM_ADDR_W-1:0] a_base;
        logic [MEM_ADDR_W-1:0] b_base;
        logic [MEM_ADDR_W-1:0] c_base;
    } pwo_base_addr_t;

endpackage

`default_nettype wire

//--- design/pwo_ctrl.sv
// Pointwise run sequencer
`default_nettype none

module pwo_ctrl #(
    parameter int NUM_WORDS = 64
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           enable_i,
    input  pwo_pkg::pwo_mode_e             mode_i,
    input  logic                           accumulate_i,
    input  pwo_pkg::pwo_base_addr_t        base_addr_i,
    output pwo_pkg::mem_req_t              a_rd_req_o,
    output pwo_pkg::mem_req_t              b_rd_req_o,
    output pwo_pkg::mem_req_t              c_rd_req_o,
    output logic                           issue_o,
    output logic [pwo_pkg::MEM_ADDR_W-1:0] word_idx_o,
    output logic                           busy_o,
    output logic                           done_o
);
    import pwo_pkg::*;

    localparam int DRAIN_W = $clog2(PIPE_LAT);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_DRAIN = 2'd2
    } state_e;

    state_e                state_q;
    logic [MEM_ADDR_W-1:0] word_cnt_q;
    logic [DRAIN_W-1:0]    drain_cnt_q;
    logic                  done_q;
    logic                  rd_active;
    logic                  last_word;

    assign rd_active = (state_q == ST_READ);
    assign last_word = (word_cnt_q == MEM_ADDR_W'(NUM_WORDS - 1));

    // ============================================================
    // FSM
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q     <= ST_IDLE;
            word_cnt_q  <= '0;
            drain_cnt_q <= '0;
            done_q      <= 1'b0;
        end else if (zeroize_i) begin
            state_q     <= ST_IDLE;
            word_cnt_q  <= '0;
            drain_cnt_q <= '0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    // Start pulse only seen here, so it is ignored while busy
                    if (enable_i) begin
                        state_q    <= ST_READ;
                        word_cnt_q <= '0;
                    end
                end
                ST_READ: begin
                    if (last_word) begin
                        state_q     <= ST_DRAIN;
                        drain_cnt_q <= '0;
                    end else begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    // Let the last word reach the C write port
                    if (drain_cnt_q == DRAIN_W'(PIPE_LAT - 1)) begin
                        state_q <= ST_IDLE;
                        done_q  <= 1'b1;
                    end else begin
                        drain_cnt_q <= drain_cnt_q + 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // One word read per cycle
    always_comb begin
        a_rd_req_o = '0;
        b_rd_req_o = '0;
        c_rd_req_o = '0;
        if (rd_active) begin
            a_rd_req_o.rd_wr_en = RW_READ;
            a_rd_req_o.addr     = base_addr_i.a_base + word_cnt_q;
            b_rd_req_o.rd_wr_en = RW_READ;
            b_rd_req_o.addr     = base_addr_i.b_base + word_cnt_q;
            // Old C only needed for multiply-accumulate
            if (accumulate_i && (mode_i == pwm)) begin
                c_rd_req_o.rd_wr_en = RW_READ;
                c_rd_req_o.addr     = base_addr_i.c_base + word_cnt_q;
            end
        end
    end

    assign issue_o    = rd_active;
    assign word_idx_o = word_cnt_q;
    assign busy_o     = (state_q != ST_IDLE);
    assign done_o     = done_q;

    // Read state ends right after the last word
    a_no_rd_outside_read : assert property (@(posedge clk) disable iff (!reset_n)
        rd_active && last_word |=> (a_rd_req_o.rd_wr_en == RW_IDLE)
                                   && (b_rd_req_o.rd_wr_en == RW_IDLE)
                                   && (c_rd_req_o.rd_wr_en == RW_IDLE));

    a_done_single : assert property (@(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o);

endmodule

`default_nettype wire

//--- design/pwo_lane.sv
// Pointwise coefficient lane
`default_nettype none

module pwo_lane (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  pwo_pkg::pwo_mode_e mode_i,
    input  logic               acc_en_i,
    input  pwo_pkg::coeff_t    a_i,
    input  pwo_pkg::coeff_t    b_i,
    input  pwo_pkg::coeff_t    c_i,
    output pwo_pkg::coeff_t    res_o
);
    import pwo_pkg::*;

    localparam int PROD_W = 2 * COEFF_W;
    localparam logic [COEFF_W:0] Q_W = (COEFF_W + 1)'(MLDSA_Q);

    coeff_t              a_q, b_q, red_q, c_q, res_q;
    logic [PROD_W-1:0]   mid_d, mid_q;
    logic [COEFF_W:0]    sum_w, acc_w;
    coeff_t              sum_red, diff_red, acc_red;

    // Add and subtract are corrected into [0, Q) before the reduce stage
    assign sum_w    = {1'b0, a_q} + {1'b0, b_q};
    assign sum_red  = (sum_w >= Q_W) ? COEFF_W'(sum_w - Q_W) : COEFF_W'(sum_w);
    assign diff_red = (a_q >= b_q) ? COEFF_W'(a_q - b_q)
                                   : COEFF_W'({1'b0, a_q} + Q_W - {1'b0, b_q});

    always_comb begin
        case (mode_i)
            pwm:     mid_d = a_q * b_q;
            pwa:     mid_d = PROD_W'(sum_red);
            pws:     mid_d = PROD_W'(diff_red);
            default: mid_d = '0;
        endcase
    end

    // Accumulate into old C
    assign acc_w   = {1'b0, red_q} + {1'b0, c_q};
    assign acc_red = (acc_w >= Q_W) ? COEFF_W'(acc_w - Q_W) : COEFF_W'(acc_w);

    // ============================================================
    // Pipeline registers
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_q   <= '0;
            b_q   <= '0;
            mid_q <= '0;
            red_q <= '0;
            c_q   <= '0;
            res_q <= '0;
        end else if (zeroize_i) begin
            a_q   <= '0;
            b_q   <= '0;
            mid_q <= '0;
            red_q <= '0;
            c_q   <= '0;
            res_q <= '0;
        end else begin
            a_q   <= a_i;
            b_q   <= b_i;
            mid_q <= mid_d;
            // Sums are already below Q, so the reduction leaves them as is
            red_q <= COEFF_W'(mid_q % PROD_W'(MLDSA_Q));
            c_q   <= c_i;
            res_q <= acc_en_i ? acc_red : red_q;
        end
    end

    assign res_o = res_q;

    a_res_in_field : assert property (@(posedge clk) disable iff (!reset_n)
        res_o < MLDSA_Q);

endmodule

`default_nettype wire

//--- design/pwo_datapath.sv
// Pointwise datapath and write request
`default_nettype none

module pwo_datapath (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  pwo_pkg::pwo_mode_e             mode_i,
    input  logic                           accumulate_i,
    input  logic                           issue_i,
    input  logic [pwo_pkg::MEM_ADDR_W-1:0] word_idx_i,
    input  logic [pwo_pkg::MEM_ADDR_W-1:0] c_base_i,
    input  pwo_pkg::mem_word_t             a_word_i,
    input  pwo_pkg::mem_word_t             b_word_i,
    input  pwo_pkg::mem_word_t             c_word_i,
    output pwo_pkg::mem_req_t              wr_req_o,
    output pwo_pkg::mem_word_t             wr_data_o
);
    import pwo_pkg::*;

    // Four tag stages then the request register
    localparam int TAG_DEPTH = PIPE_LAT - 1;

    typedef struct packed {
        logic                  vld;
        logic [MEM_ADDR_W-1:0] idx;
    } tag_t;

    tag_t      tag_q [TAG_DEPTH];
    mem_req_t  wr_req_q;
    mem_word_t c_d1_q, c_d2_q;
    logic      acc_en;

    assign acc_en = accumulate_i && (mode_i == pwm);

    // ============================================================
    // Valid and index pipeline
    // ============================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_q    <= '{default: '0};
            wr_req_q <= '0;
        end else if (zeroize_i) begin
            tag_q    <= '{default: '0};
            wr_req_q <= '0;
        end else begin
            tag_q[0] <= '{vld: issue_i, idx: word_idx_i};
            for (int s = 1; s < TAG_DEPTH; s++) begin
                tag_q[s] <= tag_q[s-1];
            end
            wr_req_q <= '0;
            if (tag_q[TAG_DEPTH-1].vld) begin
                wr_req_q.rd_wr_en <= RW_WRITE;
                wr_req_q.addr     <= c_base_i + tag_q[TAG_DEPTH-1].idx;
            end
        end
    end

    // Old C word waits two cycles for the lane accumulate stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            c_d1_q <= '0;
            c_d2_q <= '0;
        end else if (zeroize_i) begin
            c_d1_q <= '0;
            c_d2_q <= '0;
        end else begin
            c_d1_q <= c_word_i;
            c_d2_q <= c_d1_q;
        end
    end

    // ============================================================
    // Lanes
    // ============================================================
    for (genvar i = 0; i < COEFFS_PER_WORD; i++) begin : g_lane
        pwo_lane u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .mode_i    (mode_i),
            .acc_en_i  (acc_en),
            .a_i       (a_word_i[i].coeff),
            .b_i       (b_word_i[i].coeff),
            .c_i       (c_d2_q[i].coeff),
            .res_o     (wr_data_o[i].coeff)
        );
        assign wr_data_o[i].pad = '0;
    end

    assign wr_req_o = wr_req_q;

    a_write_follows_issue : assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (wr_req_o.rd_wr_en == RW_WRITE) |-> $past(issue_i, PIPE_LAT));

endmodule

`default_nettype wire

//--- design/pwo_top.sv
// Pointwise engine top level
`default_nettype none

module pwo_top #(
    parameter int NUM_WORDS = 64
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize_i,
    input  logic                    enable_i,
    input  pwo_pkg::pwo_mode_e      mode_i,
    input  logic                    accumulate_i,
    input  pwo_pkg::pwo_base_addr_t base_addr_i,

    // Operand and result memories
    output pwo_pkg::mem_req_t       a_rd_req_o,
    output pwo_pkg::mem_req_t       b_rd_req_o,
    output pwo_pkg::mem_req_t       c_rd_req_o,
    output pwo_pkg::mem_req_t       wr_req_o,
    input  pwo_pkg::mem_word_t      a_rd_data_i,
    input  pwo_pkg::mem_word_t      b_rd_data_i,
    input  pwo_pkg::mem_word_t      c_rd_data_i,
    output pwo_pkg::mem_word_t      wr_data_o,

    output logic                    busy_o,
    output logic                    done_o
);
    import pwo_pkg::*;

    logic                  issue;
    logic [MEM_ADDR_W-1:0] word_idx;

    pwo_ctrl #(
        .NUM_WORDS (NUM_WORDS)
    ) u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_addr_i  (base_addr_i),
        .a_rd_req_o   (a_rd_req_o),
        .b_rd_req_o   (b_rd_req_o),
        .c_rd_req_o   (c_rd_req_o),
        .issue_o      (issue),
        .word_idx_o   (word_idx),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    // Result words go back to C at c_base + word index
    pwo_datapath u_datapath (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .issue_i      (issue),
        .word_idx_i   (word_idx),
        .c_base_i     (base_addr_i.c_base),
        .a_word_i     (a_rd_data_i),
        .b_word_i     (b_rd_data_i),
        .c_word_i     (c_rd_data_i),
        .wr_req_o     (wr_req_o),
        .wr_data_o    (wr_data_o)
    );

endmodule

`default_nettype wire

//--- testbench/pwo_mem_model.sv
// Operand and result memories
`default_nettype none

module pwo_mem_model (
    input  logic               clk,
    input  logic               reset_n,
    input  pwo_pkg::mem_req_t  a_rd_req_i,
    input  pwo_pkg::mem_req_t  b_rd_req_i,
    input  pwo_pkg::mem_req_t  c_rd_req_i,
    input  pwo_pkg::mem_req_t  wr_req_i,
    input  pwo_pkg::mem_word_t wr_data_i,
    output pwo_pkg::mem_word_t a_rd_data_o,
    output pwo_pkg::mem_word_t b_rd_data_o,
    output pwo_pkg::mem_word_t c_rd_data_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import pwo_pkg::*;

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    // Whole address space filled by the testbench
    mem_word_t a_mem [DEPTH];
    mem_word_t b_mem [DEPTH];
    mem_word_t c_mem [DEPTH];

    // One cycle read latency and writes land in C only
    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            a_rd_data_o <= '0;
            b_rd_data_o <= '0;
            c_rd_data_o <= '0;
        end else begin
            if (a_rd_req_i.rd_wr_en == RW_READ) begin
                a_rd_data_o <= a_mem[a_rd_req_i.addr];
            end
            if (b_rd_req_i.rd_wr_en == RW_READ) begin
                b_rd_data_o <= b_mem[b_rd_req_i.addr];
            end
            if (c_rd_req_i.rd_wr_en == RW_READ) begin
                c_rd_data_o <= c_mem[c_rd_req_i.addr];
            end
            if (wr_req_i.rd_wr_en == RW_WRITE) begin
                c_mem[wr_req_i.addr] <= wr_data_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_pwo_top.sv
// Pointwise engine testbench
`default_nettype none

module tb_pwo_top;
    timeunit 1ns;
    timeprecision 1ps;
    import pwo_pkg::*;

    localparam int NUM_WORDS = 64;
    localparam int NUM_TESTS = 6;
    localparam int RESET_CYCLES = 8;
    localparam int RUN_CYCLES = NUM_WORDS + PIPE_LAT + 20;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * RUN_CYCLES + RESET_CYCLES;

    typedef struct packed {
        pwo_mode_e      mode;
        logic           acc;
        pwo_base_addr_t base;
        logic [15:0]    zeroize_cyc;
        logic [15:0]    exp_writes;
        logic           exp_done;
    } test_vec_t;

    logic           clk = 1'b0;
    logic           reset_n;
    logic           zeroize_i;
    logic           enable_i;
    logic           accumulate_i;
    pwo_mode_e      mode_i;
    pwo_base_addr_t base_addr_i;
    mem_req_t       a_rd_req, b_rd_req, c_rd_req, wr_req;
    mem_word_t      a_rd_data, b_rd_data, c_rd_data, wr_data;
    logic           busy;
    logic           done;

    test_vec_t   tests [NUM_TESTS];
    string       test_names [NUM_TESTS];
    mem_word_t   old_c [NUM_WORDS];
    mem_word_t   exp_words [NUM_WORDS];
    logic [31:0] rng_state = 32'd65079;
    int          cycle_cnt = 0;
    int          check_cnt = 0;
    int          error_cnt = 0;
    int          write_cnt;
    int          done_cnt;

    always #5 clk = ~clk;

    pwo_top #(
        .NUM_WORDS (NUM_WORDS)
    ) dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .enable_i     (enable_i),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .base_addr_i  (base_addr_i),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .wr_req_o     (wr_req),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .wr_data_o    (wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    pwo_mem_model mem0 (
        .clk         (clk),
        .reset_n     (reset_n),
        .a_rd_req_i  (a_rd_req),
        .b_rd_req_i  (b_rd_req),
        .c_rd_req_i  (c_rd_req),
        .wr_req_i    (wr_req),
        .wr_data_i   (wr_data),
        .a_rd_data_o (a_rd_data),
        .b_rd_data_o (b_rd_data),
        .c_rd_data_o (c_rd_data)
    );

    // Ends a run that never reaches its last check
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ============================================================
    // Stimulus and reference model
    // ============================================================
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic random_word(output mem_word_t w);
        w = '0;
        for (int s = 0; s < COEFFS_PER_WORD; s++) begin
            rng_state = lcg_next(rng_state);
            w[s].coeff = COEFF_W'((rng_state >> 8) % MLDSA_Q);
        end
    endtask

    function automatic mem_word_t expect_word(input pwo_mode_e mode, input logic acc,
                                              input mem_word_t a, input mem_word_t b,
                                              input mem_word_t c);
        mem_word_t       w;
        longint unsigned av, bv, cv, r;
        w = '0;
        for (int s = 0; s < COEFFS_PER_WORD; s++) begin
            av = a[s].coeff;
            bv = b[s].coeff;
            cv = c[s].coeff;
            case (mode)
                pwm: begin
                    r = (av * bv) % MLDSA_Q;
                    if (acc) begin
                        r = (r + cv) % MLDSA_Q;
                    end
                end
                pwa:     r = (av + bv) % MLDSA_Q;
                pws:     r = (av + MLDSA_Q - bv) % MLDSA_Q;
                default: r = 0;
            endcase
            w[s].coeff = COEFF_W'(r);
        end
        return w;
    endfunction

    task automatic add_row(input int idx, input string name, input pwo_mode_e mode,
                           input logic acc, input logic [MEM_ADDR_W-1:0] a_base,
                           input logic [MEM_ADDR_W-1:0] b_base,
                           input logic [MEM_ADDR_W-1:0] c_base, input int zc,
                           input int exp_writes, input logic exp_done);
        test_names[idx]        = name;
        tests[idx].mode        = mode;
        tests[idx].acc         = acc;
        tests[idx].base.a_base = a_base;
        tests[idx].base.b_base = b_base;
        tests[idx].base.c_base = c_base;
        tests[idx].zeroize_cyc = 16'(zc);
        tests[idx].exp_writes  = 16'(exp_writes);
        tests[idx].exp_done    = exp_done;
    endtask

    // ============================================================
    // Checks
    // ============================================================
    task automatic compare_value(input string name, input string what,
                                 input logic [WORD_W-1:0] exp, input logic [WORD_W-1:0] act);
        check_cnt++;
        assert (act === exp) else begin
            error_cnt++;
            $display("Mismatch in %s: %s expected %0h actual %0h", name, what, exp, act);
        end
    endtask

    task automatic expect_idle(input string name);
        compare_value(name, "a read request", '0, a_rd_req);
        compare_value(name, "b read request", '0, b_rd_req);
        compare_value(name, "c read request", '0, c_rd_req);
        compare_value(name, "write request", '0, wr_req);
        compare_value(name, "busy", '0, busy);
        compare_value(name, "done", '0, done);
    endtask

    // Cycle n counts from the first read of the run
    task automatic verify_cycle(input int idx, input int n);
        test_vec_t tv;
        string     name;
        logic      active;
        logic      rd_on;
        logic      wr_on;
        mem_req_t  exp_a, exp_b, exp_c, exp_wr;
        tv     = tests[idx];
        name   = test_names[idx];
        active = (tv.zeroize_cyc == 0) || (n <= int'(tv.zeroize_cyc));
        rd_on  = active && (n < NUM_WORDS);
        wr_on  = active && (n >= PIPE_LAT) && (n < NUM_WORDS + PIPE_LAT);
        exp_a  = '0;
        exp_b  = '0;
        exp_c  = '0;
        exp_wr = '0;
        if (rd_on) begin
            exp_a.rd_wr_en = RW_READ;
            exp_a.addr     = MEM_ADDR_W'(tv.base.a_base + n);
            exp_b.rd_wr_en = RW_READ;
            exp_b.addr     = MEM_ADDR_W'(tv.base.b_base + n);
            if (tv.acc && (tv.mode == pwm)) begin
                exp_c.rd_wr_en = RW_READ;
                exp_c.addr     = MEM_ADDR_W'(tv.base.c_base + n);
            end
        end
        if (wr_on) begin
            exp_wr.rd_wr_en = RW_WRITE;
            exp_wr.addr     = MEM_ADDR_W'(tv.base.c_base + n - PIPE_LAT);
            compare_value(name, $sformatf("write data cycle %0d", n),
                          exp_words[n - PIPE_LAT], wr_data);
        end
        compare_value(name, $sformatf("a read request cycle %0d", n), exp_a, a_rd_req);
        compare_value(name, $sformatf("b read request cycle %0d", n), exp_b, b_rd_req);
        compare_value(name, $sformatf("c read request cycle %0d", n), exp_c, c_rd_req);
        compare_value(name, $sformatf("write request cycle %0d", n), exp_wr, wr_req);
        compare_value(name, $sformatf("busy cycle %0d", n),
                      active && (n < NUM_WORDS + PIPE_LAT), busy);
        compare_value(name, $sformatf("done cycle %0d", n),
                      (tv.zeroize_cyc == 0) && (n == NUM_WORDS + PIPE_LAT), done);
        if (wr_req.rd_wr_en == RW_WRITE) begin
            write_cnt++;
        end
        if (done) begin
            done_cnt++;
        end
    endtask

    task automatic run_test(input int idx);
        test_vec_t                tv;
        logic [MEM_ADDR_W-1:0]    c_addr;
        mem_word_t                final_exp;
        tv        = tests[idx];
        write_cnt = 0;
        done_cnt  = 0;
        // Snapshot old C and build the expected words
        for (int k = 0; k < NUM_WORDS; k++) begin
            c_addr       = MEM_ADDR_W'(tv.base.c_base + k);
            old_c[k]     = mem0.c_mem[c_addr];
            exp_words[k] = expect_word(tv.mode, tv.acc,
                                       mem0.a_mem[MEM_ADDR_W'(tv.base.a_base + k)],
                                       mem0.b_mem[MEM_ADDR_W'(tv.base.b_base + k)], old_c[k]);
        end
        @(posedge clk);
        mode_i       <= tv.mode;
        accumulate_i <= tv.acc;
        base_addr_i  <= tv.base;
        enable_i     <= 1'b1;
        @(posedge clk);
        enable_i <= 1'b0;
        for (int n = 0; n <= NUM_WORDS + PIPE_LAT + 3; n++) begin
            zeroize_i <= (tv.zeroize_cyc != 0) && (n == int'(tv.zeroize_cyc));
            @(negedge clk);
            verify_cycle(idx, n);
            @(posedge clk);
        end
        compare_value(test_names[idx], "write count", tv.exp_writes, write_cnt);
        compare_value(test_names[idx], "done pulses", tv.exp_done, done_cnt);
        // Words beyond the last write keep their old value
        for (int k = 0; k < NUM_WORDS; k++) begin
            final_exp = (k < int'(tv.exp_writes)) ? exp_words[k] : old_c[k];
            compare_value(test_names[idx], $sformatf("C word %0d", k), final_exp,
                          mem0.c_mem[MEM_ADDR_W'(tv.base.c_base + k)]);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        mem_word_t w;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        enable_i     = 1'b0;
        accumulate_i = 1'b0;
        mode_i       = pwm;
        base_addr_i  = '0;

        add_row(0, "pwm_plain", pwm, 1'b0, 15'h0000, 15'h0400, 15'h0800, 0, NUM_WORDS, 1'b1);
        add_row(1, "pwm_acc", pwm, 1'b1, 15'h0040, 15'h0440, 15'h0800, 0, NUM_WORDS, 1'b1);
        add_row(2, "pwa", pwa, 1'b0, 15'h0080, 15'h0480, 15'h0840, 0, NUM_WORDS, 1'b1);
        add_row(3, "pws", pws, 1'b0, 15'h00c0, 15'h04c0, 15'h0880, 0, NUM_WORDS, 1'b1);
        // Accumulate is ignored outside multiply and the A range wraps
        add_row(4, "pws_acc", pws, 1'b1, 15'h7fe0, 15'h0500, 15'h08c0, 0, NUM_WORDS, 1'b1);
        add_row(5, "pwm_zeroize", pwm, 1'b1, 15'h0140, 15'h0540, 15'h0900, 30,
                30 - PIPE_LAT + 1, 1'b0);

        for (int i = 0; i < 2 ** MEM_ADDR_W; i++) begin
            random_word(w);
            mem0.a_mem[i] = w;
            random_word(w);
            mem0.b_mem[i] = w;
            random_word(w);
            mem0.c_mem[i] = w;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            expect_idle("reset");
            @(posedge clk);
        end
        reset_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            expect_idle("idle after reset");
            @(posedge clk);
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pwo_engine.f
design/pwo_pkg.sv
design/pwo_ctrl.sv
design/pwo_lane.sv
design/pwo_datapath.sv
design/pwo_top.sv
testbench/pwo_mem_model.sv
testbench/tb_pwo_top.sv

//--- Bender.yml
package:
  name: pwo_engine

sources:
  - files:
      - design/pwo_pkg.sv
      - design/pwo_ctrl.sv
      - design/pwo_lane.sv
      - design/pwo_datapath.sv
      - design/pwo_top.sv
  - target: simulation
    files:
      - testbench/pwo_mem_model.sv
      - testbench/tb_pwo_top.sv
